/* logic/msg_net_settings.svh */
`ifndef MSG_NET_SETTINGS_SVH
`define MSG_NET_SETTINGS_SVH

// Message field widths
`define MSG_ADDR_W 6
`define MSG_DATA_W 8
`define MSG_RED_W 4

// Fixed source address of the traffic generator
`define DBG_SRC_ADDR 9

// Destination window, wraps from max back to min
`define ADDR_MIN 1
`define ADDR_MAX 6

// Inclusive range routed to sink 0
`define ROUTE0_LO 1
`define ROUTE0_HI 3

// Largest legal data value
`define DATA_MAX 15

// APB register map
`define REG_CTRL 8'h00
`define REG_STATUS 8'h04
`define REG_ERR0 8'h08
`define REG_ERR1 8'h0C
`define REG_CNT0 8'h10
`define REG_CNT1 8'h14
`define REG_CAP0 8'h18
`define REG_CAP1 8'h1C

`endif

/* logic/msg_pkg.sv */
`include "msg_net_settings.svh"

package msg_pkg;

	typedef logic [`MSG_ADDR_W-1:0] msg_addr_t;
	typedef logic [`MSG_DATA_W-1:0] msg_data_t;
	typedef logic [`MSG_RED_W-1:0] msg_red_t;

	typedef enum logic {
		ROUTE_SINK0,
		ROUTE_SINK1
	} route_t;

	// Sink selected by destination range
	function automatic route_t route_of(msg_addr_t dst);
		if ((dst >= msg_addr_t'(`ROUTE0_LO)) && (dst <= msg_addr_t'(`ROUTE0_HI))) begin
			return ROUTE_SINK0;
		end
		return ROUTE_SINK1;
	endfunction

endpackage

/* logic/dbg_pkg.sv */
package dbg_pkg;

	// Code 4 stays unused, negative data cannot occur
	typedef enum logic [3:0] {
		ERR_NONE  = 4'd0,
		ERR_ROUTE = 4'd1,
		ERR_SRC   = 4'd2,
		ERR_RANGE = 4'd3,
		ERR_RED   = 4'd5,
		ERR_SEQ   = 4'd6
	} err_case_t;

	typedef enum logic [1:0] {
		SPLIT_IDLE,
		SPLIT_FWD,
		SPLIT_RET
	} split_state_t;

	typedef logic [15:0] msg_cnt_t;

endpackage

/* logic/redun_calc.sv */
`include "msg_net_settings.svh"

module redun_calc (
	input msg_pkg::msg_addr_t src,
	input msg_pkg::msg_addr_t dst,
	input msg_pkg::msg_data_t dat,
	output msg_pkg::msg_red_t red
);
	import msg_pkg::*;

	// Fields padded up to whole nibbles
	localparam int ADDR_PAD = 4 * ((`MSG_ADDR_W + 3) / 4);
	localparam int DATA_PAD = 4 * ((`MSG_DATA_W + 3) / 4);
	localparam int ALL_W = 2 * ADDR_PAD + DATA_PAD;

	logic [ALL_W-1:0] all_bits;
	msg_red_t sum;

	// Nibble sum, carries drop off the top
	always_comb begin
		all_bits = {ADDR_PAD'(src), ADDR_PAD'(dst), DATA_PAD'(dat)};
		sum = '0;
		for (int i = 0; i < ALL_W / 4; i++) begin
			sum = sum + all_bits[4*i +: 4];
		end
	end

	assign red = sum;

endmodule

/* logic/msg_source.sv */
`include "msg_net_settings.svh"

module msg_source (
	input logic dbg_clk,
	input logic rst,
	input logic run,
	input logic inject_red,
	output logic busy,
	output logic inject_done,
	output logic src_req,
	input logic src_ack,
	output msg_pkg::msg_addr_t src,
	output msg_pkg::msg_addr_t dst,
	output msg_pkg::msg_data_t dat,
	output msg_pkg::msg_red_t red
);
	import msg_pkg::*;

	logic [3:0] dat_cnt0;
	logic [3:0] dat_cnt1;
	logic sent;
	logic load;
	logic send;
	route_t load_route;
	msg_red_t red_calc;

	assign src = msg_addr_t'(`DBG_SRC_ADDR);
	assign load_route = route_of(dst);

	// Load when idle, request one cycle later
	assign load = !busy && run;
	assign send = busy && !sent && !src_ack;

	redun_calc u_redun (
		.src(src),
		.dst(dst),
		.dat(dat),
		.red(red_calc)
	);

	always_ff @(posedge dbg_clk) begin
		if (rst) begin
			busy <= 1'b0;
			sent <= 1'b0;
			src_req <= 1'b0;
			inject_done <= 1'b0;
			dst <= msg_addr_t'(`ADDR_MIN);
			dat_cnt0 <= '0;
			dat_cnt1 <= '0;
		end else begin
			inject_done <= 1'b0;
			if (load) begin
				busy <= 1'b1;
				// Each route keeps its own sequence
				if (load_route == ROUTE_SINK0) begin
					dat_cnt0 <= dat_cnt0 + 1'b1;
				end else begin
					dat_cnt1 <= dat_cnt1 + 1'b1;
				end
			end else if (send) begin
				src_req <= 1'b1;
				sent <= 1'b1;
				inject_done <= inject_red;
			end else if (busy && sent && src_req && src_ack) begin
				src_req <= 1'b0;
				if (dst >= msg_addr_t'(`ADDR_MAX)) begin
					dst <= msg_addr_t'(`ADDR_MIN);
				end else begin
					dst <= dst + 1'b1;
				end
			end else if (busy && sent && !src_req && !src_ack) begin
				busy <= 1'b0;
				sent <= 1'b0;
			end
		end
	end

	always_ff @(posedge dbg_clk) begin
		if (load) begin
			dat <= (load_route == ROUTE_SINK0) ? msg_data_t'(dat_cnt0) : msg_data_t'(dat_cnt1);
		end
		// Fault injection flips the low checksum bit
		if (send) begin
			red <= inject_red ? (red_calc ^ msg_red_t'(1)) : red_calc;
		end
	end

endmodule

/* logic/msg_split.sv */
module msg_split (
	input logic dbg_clk,
	input logic rst,
	input logic src_req,
	input msg_pkg::msg_addr_t src,
	input msg_pkg::msg_addr_t dst,
	input msg_pkg::msg_data_t dat,
	input msg_pkg::msg_red_t red,
	output logic src_ack,
	output logic s0_req,
	output logic s1_req,
	input logic s0_ack,
	input logic s1_ack,
	output msg_pkg::msg_addr_t m_src,
	output msg_pkg::msg_addr_t m_dst,
	output msg_pkg::msg_data_t m_dat,
	output msg_pkg::msg_red_t m_red
);
	import msg_pkg::*;
	import dbg_pkg::*;

	split_state_t state;
	route_t route;
	logic sink_ack;
	logic take;

	assign take = (state == SPLIT_IDLE) && src_req;
	assign sink_ack = (route == ROUTE_SINK0) ? s0_ack : s1_ack;

	// Only the held route sees a request
	assign s0_req = (state == SPLIT_FWD) && (route == ROUTE_SINK0);
	assign s1_req = (state == SPLIT_FWD) && (route == ROUTE_SINK1);

	always_ff @(posedge dbg_clk) begin
		if (rst) begin
			state <= SPLIT_IDLE;
			route <= ROUTE_SINK0;
			src_ack <= 1'b0;
		end else begin
			case (state)
				SPLIT_IDLE: begin
					if (take) begin
						route <= route_of(dst);
						state <= SPLIT_FWD;
					end
				end
				SPLIT_FWD: begin
					if (sink_ack) begin
						src_ack <= 1'b1;
						state <= SPLIT_RET;
					end
				end
				SPLIT_RET: begin
					// Wait for both sides to finish
					if (!src_req && !sink_ack) begin
						src_ack <= 1'b0;
						state <= SPLIT_IDLE;
					end
				end
				default: state <= SPLIT_IDLE;
			endcase
		end
	end

	always_ff @(posedge dbg_clk) begin
		if (take) begin
			m_src <= src;
			m_dst <= dst;
			m_dat <= dat;
			m_red <= red;
		end
	end

endmodule

/* logic/msg_sink_check.sv */
`include "msg_net_settings.svh"

module msg_sink_check #(
	parameter msg_pkg::route_t SINK_ROUTE = msg_pkg::ROUTE_SINK0
) (
	input logic dbg_clk,
	input logic rst,
	input logic req,
	input msg_pkg::msg_addr_t src,
	input msg_pkg::msg_addr_t dst,
	input msg_pkg::msg_data_t dat,
	input msg_pkg::msg_red_t red,
	output logic ack,
	output logic err,
	output dbg_pkg::err_case_t err_case,
	output dbg_pkg::msg_cnt_t msg_cnt,
	output msg_pkg::msg_addr_t cap_dst,
	output msg_pkg::msg_data_t cap_dat,
	output msg_pkg::msg_red_t cap_red,
	output msg_pkg::msg_red_t cap_red_calc
);
	import msg_pkg::*;
	import dbg_pkg::*;

	msg_red_t red_calc;
	logic [3:0] prev_dat;
	logic have_prev;
	logic take;
	err_case_t check_case;

	assign take = req && !ack;

	redun_calc u_redun (
		.src(src),
		.dst(dst),
		.dat(dat),
		.red(red_calc)
	);

	// Checks in priority order
	always_comb begin
		check_case = ERR_NONE;
		if (route_of(dst) != SINK_ROUTE) begin
			check_case = ERR_ROUTE;
		end else if (src != msg_addr_t'(`DBG_SRC_ADDR)) begin
			check_case = ERR_SRC;
		end else if (dat > msg_data_t'(`DATA_MAX)) begin
			check_case = ERR_RANGE;
		end else if (red != red_calc) begin
			check_case = ERR_RED;
		end else if (have_prev && (dat[3:0] != prev_dat + 1'b1)) begin
			// first message has nothing to follow
			check_case = ERR_SEQ;
		end
	end

	always_ff @(posedge dbg_clk) begin
		if (rst) begin
			ack <= 1'b0;
			err <= 1'b0;
			err_case <= ERR_NONE;
			msg_cnt <= '0;
			have_prev <= 1'b0;
			prev_dat <= '0;
			cap_dst <= '0;
			cap_dat <= '0;
			cap_red <= '0;
			cap_red_calc <= '0;
		end else if (take) begin
			ack <= 1'b1;
			msg_cnt <= msg_cnt + 1'b1;
			if (!err) begin
				if (check_case != ERR_NONE) begin
					// Latch first failure only
					err <= 1'b1;
					err_case <= check_case;
					cap_dst <= dst;
					cap_dat <= dat;
					cap_red <= red;
					cap_red_calc <= red_calc;
				end else begin
					have_prev <= 1'b1;
					prev_dat <= dat[3:0];
				end
			end
		end else if (!req && ack) begin
			ack <= 1'b0;
		end
	end

endmodule

/* logic/dbg_apb_regs.sv */
`include "msg_net_settings.svh"

module dbg_apb_regs (
	input logic dbg_clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic run,
	output logic inject_red,
	input logic busy,
	input logic inject_done,
	input logic err0,
	input logic err1,
	input dbg_pkg::err_case_t err_case0,
	input dbg_pkg::err_case_t err_case1,
	input dbg_pkg::msg_cnt_t cnt0,
	input dbg_pkg::msg_cnt_t cnt1,
	input msg_pkg::msg_addr_t cap_dst0,
	input msg_pkg::msg_data_t cap_dat0,
	input msg_pkg::msg_red_t cap_red0,
	input msg_pkg::msg_red_t cap_red_calc0,
	input msg_pkg::msg_addr_t cap_dst1,
	input msg_pkg::msg_data_t cap_dat1,
	input msg_pkg::msg_red_t cap_red1,
	input msg_pkg::msg_red_t cap_red_calc1,
	output logic [3:0] leds
);
	import msg_pkg::*;

	logic wr_en;
	logic addr_ok;

	// Captured message, one field per byte lane
	function automatic logic [31:0] pack_cap(msg_addr_t d, msg_data_t v, msg_red_t r,
			msg_red_t rc);
		logic [31:0] word;
		word = '0;
		word[24 +: `MSG_ADDR_W] = d;
		word[16 +: `MSG_DATA_W] = v;
		word[8 +: `MSG_RED_W] = r;
		word[0 +: `MSG_RED_W] = rc;
		return word;
	endfunction

	assign wr_en = psel && penable && pwrite;
	assign pready = 1'b1;
	assign pslverr = psel && penable && !addr_ok;
	assign leds = {1'b0, busy, err1, err0};

	always_comb begin
		addr_ok = 1'b1;
		case (paddr)
			`REG_CTRL: prdata = {30'b0, inject_red, run};
			`REG_STATUS: prdata = {29'b0, busy, err1, err0};
			`REG_ERR0: prdata = {28'b0, err_case0};
			`REG_ERR1: prdata = {28'b0, err_case1};
			`REG_CNT0: prdata = {16'b0, cnt0};
			`REG_CNT1: prdata = {16'b0, cnt1};
			`REG_CAP0: prdata = pack_cap(cap_dst0, cap_dat0, cap_red0, cap_red_calc0);
			`REG_CAP1: prdata = pack_cap(cap_dst1, cap_dat1, cap_red1, cap_red_calc1);
			default: begin
				prdata = '0;
				addr_ok = 1'b0;
			end
		endcase
	end

	always_ff @(posedge dbg_clk) begin
		if (rst) begin
			run <= 1'b0;
			inject_red <= 1'b0;
		end else if (wr_en && (paddr == `REG_CTRL)) begin
			run <= pwdata[0];
			inject_red <= pwdata[1];
		end else if (inject_done) begin
			// Source took the fault
			inject_red <= 1'b0;
		end
	end

endmodule

/* logic/msg_net_top.sv */
module msg_net_top (
	input logic dbg_clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [3:0] leds
);
	import msg_pkg::*;
	import dbg_pkg::*;

	logic run;
	logic inject_red;
	logic busy;
	logic inject_done;

	logic src_req;
	logic src_ack;
	msg_addr_t src;
	msg_addr_t dst;
	msg_data_t dat;
	msg_red_t red;

	logic s0_req;
	logic s0_ack;
	logic s1_req;
	logic s1_ack;
	msg_addr_t m_src;
	msg_addr_t m_dst;
	msg_data_t m_dat;
	msg_red_t m_red;

	logic err0;
	logic err1;
	err_case_t err_case0;
	err_case_t err_case1;
	msg_cnt_t cnt0;
	msg_cnt_t cnt1;
	msg_addr_t cap_dst0;
	msg_addr_t cap_dst1;
	msg_data_t cap_dat0;
	msg_data_t cap_dat1;
	msg_red_t cap_red0;
	msg_red_t cap_red1;
	msg_red_t cap_red_calc0;
	msg_red_t cap_red_calc1;

	msg_source u_source (
		.dbg_clk(dbg_clk),
		.rst(rst),
		.run(run),
		.inject_red(inject_red),
		.busy(busy),
		.inject_done(inject_done),
		.src_req(src_req),
		.src_ack(src_ack),
		.src(src),
		.dst(dst),
		.dat(dat),
		.red(red)
	);

	msg_split u_split (
		.dbg_clk(dbg_clk),
		.rst(rst),
		.src_req(src_req),
		.src(src),
		.dst(dst),
		.dat(dat),
		.red(red),
		.src_ack(src_ack),
		.s0_req(s0_req),
		.s1_req(s1_req),
		.s0_ack(s0_ack),
		.s1_ack(s1_ack),
		.m_src(m_src),
		.m_dst(m_dst),
		.m_dat(m_dat),
		.m_red(m_red)
	);

	// Both sinks share the held message fields
	msg_sink_check #(.SINK_ROUTE(ROUTE_SINK0)) u_sink0 (
		.dbg_clk(dbg_clk),
		.rst(rst),
		.req(s0_req),
		.src(m_src),
		.dst(m_dst),
		.dat(m_dat),
		.red(m_red),
		.ack(s0_ack),
		.err(err0),
		.err_case(err_case0),
		.msg_cnt(cnt0),
		.cap_dst(cap_dst0),
		.cap_dat(cap_dat0),
		.cap_red(cap_red0),
		.cap_red_calc(cap_red_calc0)
	);

	msg_sink_check #(.SINK_ROUTE(ROUTE_SINK1)) u_sink1 (
		.dbg_clk(dbg_clk),
		.rst(rst),
		.req(s1_req),
		.src(m_src),
		.dst(m_dst),
		.dat(m_dat),
		.red(m_red),
		.ack(s1_ack),
		.err(err1),
		.err_case(err_case1),
		.msg_cnt(cnt1),
		.cap_dst(cap_dst1),
		.cap_dat(cap_dat1),
		.cap_red(cap_red1),
		.cap_red_calc(cap_red_calc1)
	);

	dbg_apb_regs u_regs (
		.dbg_clk(dbg_clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.run(run),
		.inject_red(inject_red),
		.busy(busy),
		.inject_done(inject_done),
		.err0(err0),
		.err1(err1),
		.err_case0(err_case0),
		.err_case1(err_case1),
		.cnt0(cnt0),
		.cnt1(cnt1),
		.cap_dst0(cap_dst0),
		.cap_dat0(cap_dat0),
		.cap_red0(cap_red0),
		.cap_red_calc0(cap_red_calc0),
		.cap_dst1(cap_dst1),
		.cap_dat1(cap_dat1),
		.cap_red1(cap_red1),
		.cap_red_calc1(cap_red_calc1),
		.leds(leds)
	);

endmodule

/* sim/msg_net_tb.sv */
`include "msg_net_settings.svh"

module msg_net_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import dbg_pkg::*;

	// Two traffic runs plus register access and polling, ten times over
	localparam int RUN_MIN = 100;
	localparam int RUN_MAX = 400;
	localparam int TIMEOUT_CYCLES = 10 * (2 * RUN_MAX + 1200);

	logic dbg_clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [3:0] leds;

	logic chk_en = 1'b0;
	logic [31:0] chk_exp = '0;
	logic [31:0] chk_got = '0;
	string chk_name = "";
	int cycles = 0;
	logic busy_prev = 1'b0;
	int busy_rises = 0;

	msg_net_top dut0 (
		.dbg_clk(dbg_clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.leds(leds)
	);

	always #50 dbg_clk = !dbg_clk;

	always @(posedge dbg_clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, traffic or polling never finished", cycles);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	// Every rise of the busy led is one message loaded
	always @(negedge dbg_clk) begin
		busy_prev <= leds[2];
		if (leds[2] && !busy_prev) begin
			busy_rises <= busy_rises + 1;
		end
	end

	function automatic string reg_name(logic [7:0] addr);
		case (addr)
			`REG_CTRL: return "CTRL";
			`REG_STATUS: return "STATUS";
			`REG_ERR0: return "ERR0";
			`REG_ERR1: return "ERR1";
			`REG_CNT0: return "CNT0";
			`REG_CNT1: return "CNT1";
			`REG_CAP0: return "CAP0";
			`REG_CAP1: return "CAP1";
			default: return "unmapped";
		endcase
	endfunction

	function automatic logic unmapped(logic [7:0] addr);
		return (addr > `REG_CAP1) || (addr[1:0] != 2'b00);
	endfunction

	// Destination of the k-th message since reset
	function automatic int dst_at(int k);
		return `ADDR_MIN + (k % (`ADDR_MAX - `ADDR_MIN + 1));
	endfunction

	function automatic logic to_sink0(int d);
		return (d >= `ROUTE0_LO) && (d <= `ROUTE0_HI);
	endfunction

	function automatic int sink0_share(int total);
		int n;
		int k;
		n = 0;
		for (k = 0; k < total; k++) begin
			if (to_sink0(dst_at(k))) begin
				n++;
			end
		end
		return n;
	endfunction

	// Sum of all nibbles, modulo 16
	function automatic logic [3:0] nibble_sum(logic [31:0] s, logic [31:0] d, logic [31:0] v);
		logic [3:0] sum;
		int i;
		sum = 4'd0;
		for (i = 0; i < 8; i++) begin
			sum = sum + s[4*i +: 4] + d[4*i +: 4] + v[4*i +: 4];
		end
		return sum;
	endfunction

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge dbg_clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge dbg_clk);
		penable <= 1'b1;
		@(posedge dbg_clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
			output logic err);
		@(posedge dbg_clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge dbg_clk);
		penable <= 1'b1;
		// Mid access phase
		@(negedge dbg_clk);
		data = prdata;
		err = pslverr;
		@(posedge dbg_clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		@(negedge dbg_clk);
		chk_name = name;
		chk_exp = exp;
		chk_got = got;
		chk_en = 1'b1;
		@(negedge dbg_clk);
		chk_en = 1'b0;
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] rd;
		logic err;
		apb_read(addr, rd, err);
		check_value(reg_name(addr), exp, rd);
	endtask

	task automatic wait_idle();
		logic [31:0] rd;
		logic err;
		rd = 32'h4;
		while (rd[2]) begin
			apb_read(`REG_STATUS, rd, err);
		end
	endtask

	task automatic check_counters(input int prev_total, output int total, output int c0,
			output int c1);
		logic [31:0] rd;
		logic err;
		total = busy_rises;
		apb_read(`REG_CNT0, rd, err);
		c0 = int'(rd);
		apb_read(`REG_CNT1, rd, err);
		c1 = int'(rd);
		check_value("message total grew", 32'd1, (total > prev_total) ? 32'd1 : 32'd0);
		check_value("CNT0+CNT1", 32'(total), 32'(c0 + c1));
		check_value("CNT0", 32'(sink0_share(total)), 32'(c0));
		check_value("CNT1", 32'(total - sink0_share(total)), 32'(c1));
	endtask

	a_value: assert property (@(posedge dbg_clk) chk_en |-> (chk_got == chk_exp))
		else begin
			$display("ERROR %0t %s expected 0x%0h got 0x%0h", $time, chk_name, chk_exp,
				chk_got);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end

	a_pready: assert property (@(posedge dbg_clk) disable iff (rst) pready)
		else begin
			$display("ERROR %0t pready expected 1 got %0b", $time, pready);
			$display("TEST FAILED");
			$fatal(1, "pready low");
		end

	a_slverr: assert property (@(posedge dbg_clk) disable iff (rst)
			(psel && penable) |-> (pslverr == unmapped(paddr)))
		else begin
			$display("ERROR %0t pslverr expected %0b got %0b", $time, unmapped(paddr),
				pslverr);
			$display("TEST FAILED");
			$fatal(1, "pslverr mismatch");
		end

	initial begin : scenario
		logic [31:0] rd;
		logic err;
		int i;
		int total;
		int prev_total;
		int cnt0_v;
		int cnt1_v;
		int run_cycles;
		int fault_dst;
		int fault_sink;
		int exp_dat;
		int prev_fail;
		logic [31:0] exp_red_calc;
		logic [31:0] exp_status;

		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'h0;
		void'($urandom(15));
		repeat (5) @(posedge dbg_clk);
		rst <= 1'b0;

		for (i = 0; i < 8; i++) begin
			read_check(8'(4 * i), 32'd0);
		end
		@(negedge dbg_clk);
		check_value("leds", 32'd0, 32'(leds));
		check_value("pready", 32'd1, 32'(pready));

		apb_write(`REG_CTRL, 32'h1);
		read_check(`REG_CTRL, 32'h1);
		apb_write(`REG_CTRL, 32'h0);
		read_check(`REG_CTRL, 32'h0);
		wait_idle();
		apb_read(8'h40, rd, err);
		check_value("pslverr", 32'd1, 32'(err));

		// Plain traffic
		prev_total = busy_rises;
		run_cycles = RUN_MIN + int'($urandom % (RUN_MAX - RUN_MIN + 1));
		apb_write(`REG_CTRL, 32'h1);
		repeat (run_cycles) @(posedge dbg_clk);
		apb_write(`REG_CTRL, 32'h0);
		wait_idle();
		check_counters(prev_total, total, cnt0_v, cnt1_v);
		read_check(`REG_STATUS, 32'h0);
		read_check(`REG_ERR0, 32'h0);
		read_check(`REG_ERR1, 32'h0);

		// Next message takes the checksum fault
		fault_dst = dst_at(total);
		fault_sink = to_sink0(fault_dst) ? 0 : 1;
		prev_fail = (fault_sink == 0) ? cnt0_v : cnt1_v;
		exp_dat = prev_fail % 16;
		exp_red_calc = 32'(nibble_sum(`DBG_SRC_ADDR, fault_dst, exp_dat));
		prev_total = total;
		apb_write(`REG_CTRL, 32'h3);
		rd = 32'h2;
		while (rd[1]) begin
			apb_read(`REG_CTRL, rd, err);
		end
		run_cycles = RUN_MIN + int'($urandom % (RUN_MAX - RUN_MIN + 1));
		repeat (run_cycles) @(posedge dbg_clk);
		apb_write(`REG_CTRL, 32'h0);
		wait_idle();
		check_counters(prev_total, total, cnt0_v, cnt1_v);

		exp_status = (fault_sink == 0) ? 32'h1 : 32'h2;
		read_check(`REG_STATUS, exp_status);
		@(negedge dbg_clk);
		check_value("leds", exp_status, 32'(leds));
		read_check((fault_sink == 0) ? `REG_ERR0 : `REG_ERR1, 32'(ERR_RED));
		read_check((fault_sink == 0) ? `REG_ERR1 : `REG_ERR0, 32'h0);
		apb_read((fault_sink == 0) ? `REG_CAP0 : `REG_CAP1, rd, err);
		check_value("captured dst", 32'(fault_dst), 32'(rd[24 +: `MSG_ADDR_W]));
		check_value("captured dat", 32'(exp_dat), 32'(rd[16 +: `MSG_DATA_W]));
		check_value("captured red_calc", exp_red_calc, 32'(rd[0 +: `MSG_RED_W]));
		check_value("captured red", exp_red_calc ^ 32'd1, 32'(rd[8 +: `MSG_RED_W]));
		// Failing sink keeps acking
		check_value("failing sink count grew", 32'd1,
			(((fault_sink == 0) ? cnt0_v : cnt1_v) > prev_fail + 1) ? 32'd1 : 32'd0);

		$display("TEST OK");
		$finish;
	end

endmodule

/* msg_net.f */
+incdir+logic
logic/msg_pkg.sv
logic/dbg_pkg.sv
logic/redun_calc.sv
logic/msg_source.sv
logic/msg_split.sv
logic/msg_sink_check.sv
logic/dbg_apb_regs.sv
logic/msg_net_top.sv
sim/msg_net_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
TOP := msg_net_tb
FILELIST := msg_net.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
